/* axis_initiator.f */
hdl/axis_pkg.sv
hdl/stream_cmd_if.sv
hdl/command_register.sv
hdl/byte_buffer.sv
hdl/beat_sequencer.sv
hdl/axis_initiator.sv
verification/clock_gen.sv
verification/axis_initiator_sva.sv
verification/axis_initiator_tb.sv

/* hdl/axis_initiator.sv */
`timescale 1ns/1ps

module axis_initiator (
    input  logic                 clock,
    input  logic                 rst,

    // Buffer write
    input  logic                 buf_wr_en,
    input  axis_pkg::byte_addr_t buf_wr_addr,
    input  logic [7:0]           buf_wr_data,

    // Command
    input  logic                 cmd_req,
    input  axis_pkg::byte_addr_t cmd_src_addr,
    input  axis_pkg::byte_len_t  cmd_len,
    input  axis_pkg::dest_t      cmd_dest,
    output logic                 cmd_ack,

    // AXI4-Stream master
    input  logic                 tready,
    output logic                 tvalid,
    output axis_pkg::data_t      tdata,
    output axis_pkg::keep_t      tkeep,
    output logic                 tlast,
    output axis_pkg::dest_t      tdest
);
    import axis_pkg::*;

    byte_addr_t rd_addr;
    data_t      rd_data;

    stream_cmd_if cmd_bus ();

    command_register command_register_inst (
        .clock        (clock),
        .rst          (rst),
        .cmd_req      (cmd_req),
        .cmd_src_addr (cmd_src_addr),
        .cmd_len      (cmd_len),
        .cmd_dest     (cmd_dest),
        .cmd_ack      (cmd_ack),
        .cmd          (cmd_bus.cmd_source)
    );

    byte_buffer byte_buffer_inst (
        .clock   (clock),
        .wr_en   (buf_wr_en),
        .wr_addr (buf_wr_addr),
        .wr_data (buf_wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    beat_sequencer beat_sequencer_inst (
        .clock   (clock),
        .rst     (rst),
        .cmd     (cmd_bus.cmd_sink),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .tready  (tready),
        .tvalid  (tvalid),
        .tdata   (tdata),
        .tkeep   (tkeep),
        .tlast   (tlast),
        .tdest   (tdest)
    );

endmodule

/* hdl/axis_pkg.sv */
package axis_pkg;

    //////////////////////////////////////////////////
    // Stream and buffer sizes
    //////////////////////////////////////////////////
    localparam int DATA_BYTES = 4;
    localparam int DATA_WIDTH = 8 * DATA_BYTES;

    // 1024-byte buffer
    localparam int ADDR_WIDTH = 10;

    // Lengths run from 1 up to the full buffer
    localparam int LEN_WIDTH  = 11;
    localparam int DEST_WIDTH = 2;

    //////////////////////////////////////////////////
    // Common types
    //////////////////////////////////////////////////
    typedef logic [ADDR_WIDTH-1:0] byte_addr_t;
    typedef logic [LEN_WIDTH-1:0]  byte_len_t;
    typedef logic [DEST_WIDTH-1:0] dest_t;

    // Lane i sits in bits 8i+7 down to 8i
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [DATA_BYTES-1:0] keep_t;

    // Sequencer states
    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_SEND,
        SEQ_DONE
    } seq_state_t;

endpackage

/* hdl/beat_sequencer.sv */
`timescale 1ns/1ps

module beat_sequencer (
    input  logic                  clock,
    input  logic                  rst,
    stream_cmd_if.cmd_sink        cmd,
    output axis_pkg::byte_addr_t  rd_addr,
    input  axis_pkg::data_t       rd_data,
    input  logic                  tready,
    output logic                  tvalid,
    output axis_pkg::data_t       tdata,
    output axis_pkg::keep_t       tkeep,
    output logic                  tlast,
    output axis_pkg::dest_t       tdest
);
    import axis_pkg::*;

    seq_state_t state;
    byte_addr_t addr_q;
    byte_len_t  remain_q;
    byte_len_t  remain_next;
    byte_len_t  beat_len;
    logic       xfer;
    logic       first;
    logic       load;

    // Low n lanes set, all four when n is 4 or more
    function automatic keep_t keep_mask(input byte_len_t n);
        keep_t mask;
        for (int i = 0; i < DATA_BYTES; i++)
        begin
            mask[i] = (n > byte_len_t'(i));
        end
        return mask;
    endfunction

    assign xfer        = tvalid && tready;
    assign first       = (state == SEQ_IDLE) && cmd.start;
    assign load        = first || ((state == SEQ_SEND) && xfer && !tlast);
    assign remain_next = remain_q - byte_len_t'(DATA_BYTES);

    // Bytes left counting the beat being loaded
    assign beat_len = first ? cmd.len : remain_next;

    // Next beat is read ahead so it loads on the transfer edge
    assign rd_addr = (state == SEQ_IDLE) ? cmd.src_addr : addr_q;

    assign cmd.done = (state == SEQ_DONE);

    //////////////////////////////////////////////////
    // Sequencer FSM
    //////////////////////////////////////////////////
    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            state    <= SEQ_IDLE;
            tvalid   <= 1'b0;
            tlast    <= 1'b0;
            remain_q <= '0;
        end
        else
        begin
            case (state)
                SEQ_IDLE:
                begin
                    if (cmd.start)
                    begin
                        state <= SEQ_SEND;
                        tvalid <= 1'b1;
                    end
                end
                SEQ_SEND:
                begin
                    if (xfer && tlast)
                    begin
                        state  <= SEQ_DONE;
                        tvalid <= 1'b0;
                        tlast  <= 1'b0;
                    end
                end
                SEQ_DONE:
                begin
                    state <= SEQ_IDLE;
                end
                default:
                begin
                    state <= SEQ_IDLE;
                end
            endcase

            if (load)
            begin
                tlast    <= (beat_len <= byte_len_t'(DATA_BYTES));
                remain_q <= beat_len;
            end
        end
    end

    //////////////////////////////////////////////////
    // Beat payload
    //////////////////////////////////////////////////
    always_ff @(posedge clock)
    begin
        if (load)
        begin
            tdata  <= rd_data;
            tkeep  <= keep_mask(beat_len);
            addr_q <= rd_addr + byte_addr_t'(DATA_BYTES);
        end
        // Route value is fixed for the whole packet
        if (first)
        begin
            tdest <= cmd.dest;
        end
    end

endmodule

/* hdl/byte_buffer.sv */
`timescale 1ns/1ps

module byte_buffer (
    input  logic                 clock,
    input  logic                 wr_en,
    input  axis_pkg::byte_addr_t wr_addr,
    input  logic [7:0]           wr_data,
    input  axis_pkg::byte_addr_t rd_addr,
    output axis_pkg::data_t      rd_data
);
    import axis_pkg::*;

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    logic [7:0] mem [0:DEPTH-1];

    //////////////////////////////////////////////////
    // Byte write port
    //////////////////////////////////////////////////
    always_ff @(posedge clock)
    begin
        if (wr_en)
        begin
            mem[wr_addr] <= wr_data;
        end
    end

    //////////////////////////////////////////////////
    // Four-lane read
    //////////////////////////////////////////////////
    // Lane address wraps at the end of the buffer
    for (genvar lane = 0; lane < DATA_BYTES; lane++)
    begin : g_lane
        byte_addr_t lane_addr;

        assign lane_addr = rd_addr + byte_addr_t'(lane);
        assign rd_data[8*lane +: 8] = mem[lane_addr];
    end

endmodule

/* hdl/command_register.sv */
`timescale 1ns/1ps

module command_register (
    input  logic                 clock,
    input  logic                 rst,
    input  logic                 cmd_req,
    input  axis_pkg::byte_addr_t cmd_src_addr,
    input  axis_pkg::byte_len_t  cmd_len,
    input  axis_pkg::dest_t      cmd_dest,
    output logic                 cmd_ack,
    stream_cmd_if.cmd_source     cmd
);
    import axis_pkg::*;

    logic       busy;
    logic       start_q;
    logic       accept;
    byte_addr_t src_addr_q;
    byte_len_t  len_q;
    dest_t      dest_q;

    // New request only when neither sending nor acknowledging
    assign accept = cmd_req && !busy && !cmd_ack;

    //////////////////////////////////////////////////
    // Four-phase handshake
    //////////////////////////////////////////////////
    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            busy    <= 1'b0;
            cmd_ack <= 1'b0;
            start_q <= 1'b0;
        end
        else
        begin
            start_q <= accept;
            if (accept)
            begin
                busy <= 1'b1;
            end
            else if (busy && cmd.done)
            begin
                busy    <= 1'b0;
                cmd_ack <= 1'b1;
            end
            else if (cmd_ack && !cmd_req)
            begin
                // Caller has released the request
                cmd_ack <= 1'b0;
            end
        end
    end

    // Command fields held for the whole packet
    always_ff @(posedge clock)
    begin
        if (accept)
        begin
            src_addr_q <= cmd_src_addr;
            len_q      <= cmd_len;
            dest_q     <= cmd_dest;
        end
    end

    assign cmd.start    = start_q;
    assign cmd.src_addr = src_addr_q;
    assign cmd.len      = len_q;
    assign cmd.dest     = dest_q;

endmodule

/* hdl/stream_cmd_if.sv */
`timescale 1ns/1ps

interface stream_cmd_if;
    import axis_pkg::*;

    // One-cycle pulse that launches a packet
    logic       start;

    // Command fields, stable from start until done
    byte_addr_t src_addr;
    byte_len_t  len;
    dest_t      dest;

    // Pulse in the cycle after the tlast transfer
    logic       done;

    modport cmd_source (
        output start,
        output src_addr,
        output len,
        output dest,
        input  done
    );

    modport cmd_sink (
        input  start,
        input  src_addr,
        input  len,
        input  dest,
        output done
    );

endinterface

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module axis_initiator_tb \
    -f axis_initiator.f \
    -o axis_initiator_sim

./obj_dir/axis_initiator_sim | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
    echo "Simulation ended without a result line"
    exit 1
fi

/* verification/axis_initiator_sva.sv */
`timescale 1ns/1ps

module axis_initiator_sva (
    input logic                clock,
    input logic                rst,
    input logic                cmd_req,
    input axis_pkg::byte_len_t cmd_len,
    input logic                tready,
    input logic                tvalid,
    input axis_pkg::data_t     tdata,
    input axis_pkg::keep_t     tkeep,
    input logic                tlast,
    input axis_pkg::dest_t     tdest
);

    // Stalled beat keeps its payload
    held_beat_stable: assert property (@(posedge clock) disable iff (rst)
        (tvalid && !tready) |=> ($stable(tdata) && $stable(tkeep)
                                 && $stable(tlast) && $stable(tdest)))
    else $error("Stream beat changed while stalled");

    // No withdrawal of a pending beat
    valid_held: assert property (@(posedge clock) disable iff (rst)
        (tvalid && !tready) |=> tvalid)
    else $error("tvalid fell without a transfer");

    nonzero_len: assert property (@(posedge clock) disable iff (rst)
        $rose(cmd_req) |-> (cmd_len != '0))
    else $error("Command raised with a zero length");

endmodule

/* verification/axis_initiator_tb.sv */
`timescale 1ns/1ps

module axis_initiator_tb;
    import axis_pkg::*;

    localparam int NUM_TESTS = 10;

    typedef struct packed {
        byte_addr_t src;
        byte_len_t  len;
        dest_t      dest;
        logic       random_ready;
    } test_t;

    logic        clock;
    logic        rst;
    logic        buf_wr_en;
    byte_addr_t  buf_wr_addr;
    logic [7:0]  buf_wr_data;
    logic        cmd_req;
    byte_addr_t  cmd_src_addr;
    byte_len_t   cmd_len;
    dest_t       cmd_dest;
    logic        cmd_ack;
    logic        tready;
    logic        tvalid;
    data_t       tdata;
    keep_t       tkeep;
    logic        tlast;
    dest_t       tdest;

    test_t       tests [NUM_TESTS];
    logic [7:0]  model [0:1023];
    logic [31:0] rng = 32'hcca9;
    logic        running = 1'b0;
    int          cycles = 0;
    int          cycle_limit = 0;

    clock_gen clock_gen_inst (.clock(clock), .rst(rst));

    axis_initiator axis_initiator_inst (.*);

    bind axis_initiator axis_initiator_sva axis_initiator_sva_inst (
        .clock, .rst, .cmd_req, .cmd_len, .tready,
        .tvalid, .tdata, .tkeep, .tlast, .tdest
    );

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("Simulation finished: FAIL");
        $fatal(1, "Stopped at the first error");
    endtask

    //////////////////////////////////////////////////
    // Watchdog over the packet phase
    //////////////////////////////////////////////////
    always @(posedge clock)
    begin
        if (running)
        begin
            cycles = cycles + 1;
            if (cycles > cycle_limit)
            begin
                stop_on_error($sformatf("Timeout: packets still running after %0d cycles",
                                        cycle_limit));
            end
        end
    end

    // Beats of one command checked on the falling edge before they transfer
    task automatic run_packet(input test_t t);
        int         nbeats;
        int         k;
        int         n;
        keep_t      exp_keep;
        byte_addr_t a;
        logic [7:0] got;
        logic       last_seen;

        nbeats = (int'(t.len) + 3) / 4;
        k = 0;
        last_seen = 1'b0;
        cmd_src_addr = t.src;
        cmd_len = t.len;
        cmd_dest = t.dest;
        cmd_req = 1'b1;
        while (!cmd_ack)
        begin
            if (t.random_ready)
            begin
                rng = next_random(rng);
                tready = rng[0];
            end
            else
            begin
                tready = 1'b1;
            end
            if (tvalid && tready)
            begin
                assert (k < nbeats)
                else stop_on_error($sformatf("Fail at %0t: extra beat %0d, expected %0d beats",
                                             $time, k, nbeats));
                assert (tlast == (k == nbeats - 1))
                else stop_on_error($sformatf("Fail at %0t: tlast %0b on beat %0d of %0d",
                                             $time, tlast, k, nbeats));
                n = int'(t.len) - 4 * k;
                exp_keep = (n >= 4) ? 4'b1111 : keep_t'((1 << n) - 1);
                assert (tkeep == exp_keep)
                else stop_on_error($sformatf("Fail at %0t: tkeep %b, expected %b on beat %0d",
                                             $time, tkeep, exp_keep, k));
                assert (tdest == t.dest)
                else stop_on_error($sformatf("Fail at %0t: tdest %0d, expected %0d",
                                             $time, tdest, t.dest));
                for (int i = 0; i < 4; i++)
                begin
                    a = t.src + byte_addr_t'(4 * k + i);
                    got = 8'(tdata >> (8 * i));
                    assert (!exp_keep[2'(i)] || got == model[a])
                    else stop_on_error(
                        $sformatf("Fail at %0t: lane %0d of beat %0d is %h, expected %h",
                                  $time, i, k, got, model[a]));
                end
                last_seen = tlast;
                k++;
            end
            @(negedge clock);
        end
        assert (last_seen && k == nbeats)
        else stop_on_error($sformatf("Fail at %0t: cmd_ack rose after %0d of %0d beats",
                                     $time, k, nbeats));

        // Stream stays idle once the request is released
        cmd_req = 1'b0;
        tready = 1'b1;
        while (cmd_ack)
        begin
            @(negedge clock);
            assert (!tvalid)
            else stop_on_error($sformatf("Fail at %0t: tvalid while cmd_ack falls", $time));
        end
        repeat (2)
        begin
            @(negedge clock);
            assert (!tvalid)
            else stop_on_error($sformatf("Fail at %0t: tvalid without a request", $time));
        end
    endtask

    initial
    begin
        buf_wr_en = 1'b0;
        buf_wr_addr = '0;
        buf_wr_data = '0;
        cmd_req = 1'b0;
        cmd_src_addr = '0;
        cmd_len = '0;
        cmd_dest = '0;
        tready = 1'b0;

        // Source, length, route, random tready
        tests[0] = '{10'h000, 11'd1, 2'd0, 1'b0};
        tests[1] = '{10'h011, 11'd2, 2'd1, 1'b0};
        tests[2] = '{10'h022, 11'd3, 2'd2, 1'b0};
        tests[3] = '{10'h033, 11'd4, 2'd3, 1'b0};
        tests[4] = '{10'h101, 11'd5, 2'd0, 1'b1};
        tests[5] = '{10'h203, 11'd8, 2'd1, 1'b1};
        tests[6] = '{10'h2f7, 11'd13, 2'd2, 1'b0};
        tests[7] = '{10'h3f6, 11'd20, 2'd3, 1'b1};
        tests[8] = '{10'h155, 11'd1024, 2'd1, 1'b0};
        tests[9] = '{10'h3e9, 11'd37, 2'd2, 1'b1};

        @(negedge rst);
        @(negedge clock);

        // Fill the buffer and its model
        for (int i = 0; i < 1024; i++)
        begin
            rng = next_random(rng);
            buf_wr_en = 1'b1;
            buf_wr_addr = byte_addr_t'(i);
            buf_wr_data = rng[7:0];
            model[buf_wr_addr] = rng[7:0];
            @(negedge clock);
        end
        buf_wr_en = 1'b0;

        for (int t = 0; t < NUM_TESTS; t++)
        begin
            cycle_limit += 8 * ((int'(tests[t].len) + 3) / 4);
        end
        cycle_limit += 200;
        running = 1'b1;

        for (int t = 0; t < NUM_TESTS; t++)
        begin
            run_packet(tests[t]);
        end
        running = 1'b0;
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* verification/clock_gen.sv */
`timescale 1ns/1ps

module clock_gen (
    output logic clock,
    output logic rst
);
    // 40 ns period
    initial
    begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // Held over four rising edges, released on a falling edge
    initial
    begin
        rst = 1'b1;
        repeat (4) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;
    end

endmodule
